// ==== filelist.f ====
logic/fetch_pkg.sv
logic/fetch_fifo.sv
logic/fetch_req_ctrl.sv
logic/fetch_unit.sv
bench/tb_clock_gen.sv
bench/tb_axi_mem.sv
bench/fetch_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch unit bench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_unit_tb \
  -f filelist.f -o fetch_unit_sim \
  && ./obj_dir/fetch_unit_sim | tee /dev/stderr | grep -q "All checks passed" \
  && exit 0 \
  || exit 1

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps
/* Bench for the fetch unit with NUM_REQS = 2 and a 256-word memory that wraps
   A reference walk of the memory predicts every accepted instruction
   All checks are concurrent assertions; the first failure ends the run */
module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int unsigned NUM_REQS  = 2;
  localparam int          MEM_WORDS = 256;
  localparam int          TIMEOUT   = 2000;

  logic              clk;
  logic              rst_n;
  logic              req;
  logic              branch;
  logic [ADDR_W-1:0] branch_addr;
  logic              out_valid;
  logic              out_ready;
  logic [ADDR_W-1:0] out_addr;
  logic [DATA_W-1:0] out_rdata;
  logic              out_err;
  logic [ADDR_W-1:0] m_araddr;
  logic              m_arvalid;
  logic              m_arready;
  logic              m_rvalid;
  logic [DATA_W-1:0] m_rdata;
  axi_resp_e         m_rresp;

  logic [31:0]       rnd;
  logic              random_ready;
  string             phase;

  // Reference copy of memory and error marks
  logic [31:0]       ref_mem [MEM_WORDS];
  logic              ref_bad [MEM_WORDS];

  // Reference walk state
  logic              started;
  logic [31:0]       ref_addr;
  int                in_flight;
  int                fire_count;
  logic              fire;
  logic [7:0]        w_cur;
  logic [7:0]        w_nxt;
  logic [15:0]       exp_lo;
  logic [15:0]       exp_hi;
  logic              exp_is32;
  logic [31:0]       exp_mask;
  logic [31:0]       exp_data;
  logic              exp_err;

  // Controller left its idle state
  logic              ctrl_busy;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tb_axi_mem u_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .rnd_i     (rnd),
    .araddr_i  (m_araddr),
    .arvalid_i (m_arvalid),
    .arready_o (m_arready),
    .rvalid_o  (m_rvalid),
    .rdata_o   (m_rdata),
    .rresp_o   (m_rresp)
  );

  fetch_unit #(
    .NUM_REQS (NUM_REQS)
  ) u_fetch_unit (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .out_addr_o    (out_addr),
    .out_rdata_o   (out_rdata),
    .out_err_o     (out_err),
    .m_araddr_o    (m_araddr),
    .m_arvalid_o   (m_arvalid),
    .m_arready_i   (m_arready),
    .m_rvalid_i    (m_rvalid),
    .m_rdata_i     (m_rdata),
    .m_rresp_i     (m_rresp)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    abort_run($sformatf("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp_v, act_v));
  endtask

  // Ends 1 ns after a rising edge, where stimulus changes
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_branch(input logic [31:0] target);
    branch      = 1'b1;
    branch_addr = target;
    step_cycle();
    branch      = 1'b0;
  endtask

  task automatic wait_for_reset();
    for (int i = 0; i < TIMEOUT && !rst_n; i++) begin
      step_cycle();
    end
    if (!rst_n) begin
      abort_run("Timeout: reset was never released");
    end
  endtask

  task automatic wait_for_fires(input int n);
    int target;
    target = fire_count + n;
    for (int i = 0; i < TIMEOUT && fire_count < target; i++) begin
      step_cycle();
    end
    if (fire_count < target) begin
      abort_run($sformatf("Timeout: fewer than %0d instructions came out in %s", n, phase));
    end
  endtask

  task automatic wait_for_read_in_flight();
    for (int i = 0; i < TIMEOUT && in_flight == 0 && !m_arvalid; i++) begin
      step_cycle();
    end
    if (in_flight == 0 && !m_arvalid) begin
      abort_run("Timeout: no read was outstanding to branch over");
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  assign fire = out_valid & out_ready;

  assign ctrl_busy = (u_fetch_unit.u_req_ctrl.state_q != REQ_IDLE);

  // Instruction at ref_addr, split by the size rule
  always_comb begin
    w_cur = ref_addr[9:2];
    w_nxt = w_cur + 8'd1;
    if (ref_addr[1]) begin
      exp_lo = ref_mem[w_cur][31:16];
      exp_hi = ref_mem[w_nxt][15:0];
    end else begin
      exp_lo = ref_mem[w_cur][15:0];
      exp_hi = ref_mem[w_cur][31:16];
    end
    exp_is32 = (exp_lo[1:0] == 2'b11);
    exp_mask = exp_is32 ? 32'hFFFF_FFFF : 32'h0000_FFFF;
    exp_data = {exp_hi, exp_lo} & exp_mask;
    // Second word only counts when the instruction spans it
    exp_err  = ref_bad[w_cur] | (exp_is32 & ref_addr[1] & ref_bad[w_nxt]);
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started    <= 1'b0;
      ref_addr   <= '0;
      in_flight  <= 0;
      fire_count <= 0;
    end else begin
      if (branch) begin
        started  <= 1'b1;
        ref_addr <= branch_addr;
      end else if (fire) begin
        ref_addr <= ref_addr + (exp_is32 ? 32'd4 : 32'd2);
      end
      if (fire) begin
        fire_count <= fire_count + 1;
      end
      // Discarded responses still retire a read
      in_flight <= in_flight + int'(m_arvalid && m_arready) - int'(m_rvalid);
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Controller state stays REQ_IDLE along with both valids
  idle_check: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> (!ctrl_busy && !m_arvalid && !out_valid))
    else report_mismatch("idle_after_reset", 32'd0,
                         {29'd0, $sampled(ctrl_busy), $sampled(m_arvalid),
                          $sampled(out_valid)});

  // Also catches lost, repeated or stale instructions
  addr_check: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> (out_addr == ref_addr))
    else report_mismatch({phase, " addr"}, $sampled(ref_addr), $sampled(out_addr));

  data_check: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> ((out_rdata & exp_mask) == exp_data))
    else report_mismatch({phase, " data"}, $sampled(exp_data),
                         $sampled(out_rdata & exp_mask));

  err_check: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> (out_err == exp_err))
    else report_mismatch({phase, " err"}, {31'd0, $sampled(exp_err)},
                         {31'd0, $sampled(out_err)});

  inflight_check: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= int'(NUM_REQS))
    else report_mismatch({phase, " reads in flight"}, NUM_REQS, $sampled(in_flight));

  ar_hold_check: assert property (@(posedge clk) disable iff (!rst_n)
    (m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_araddr)))
    else abort_run($sformatf("AR request changed before it was accepted in %s", phase));

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Random word and consumer ready, both 1 ns after each edge
  initial begin
    rnd       = 32'd73943;
    out_ready = 1'b0;
    forever begin
      step_cycle();
      rnd       = lcg_next(rnd);
      out_ready = random_ready ? rnd[27] : 1'b1;
    end
  end

  initial begin
    logic [31:0] seed;
    logic [31:0] word;
    req          = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    random_ready = 1'b0;
    phase        = "idle_after_reset";

    // Words 0 to 31 hold only aligned 32-bit instructions, the rest a mix
    seed = 32'd73943;
    for (int i = 0; i < MEM_WORDS; i++) begin
      seed = lcg_next(seed);
      word[31:16] = seed[31:16];
      seed = lcg_next(seed);
      word[15:0] = seed[31:16];
      seed = lcg_next(seed);
      if (i < 32) begin
        word[1:0] = 2'b11;
      end else begin
        word[1:0]   = seed[31] ? 2'b11 : {1'b0, word[0]};
        word[17:16] = seed[30] ? 2'b11 : {1'b0, word[16]};
      end
      ref_mem[i]   = word;
      ref_bad[i]   = (i == 70) || (i == 71) || (i == 97) || (i == 150);
      u_mem.mem[i] = word;
      u_mem.bad[i] = ref_bad[i];
    end

    wait_for_reset();
    // Requesting alone must not start fetch
    req = 1'b1;
    for (int i = 0; i < 12; i++) begin
      step_cycle();
    end

    phase = "aligned_32";
    apply_branch(32'h0000_0000);
    wait_for_fires(20);

    phase = "mixed_16_32";
    apply_branch(32'h0000_0100);
    wait_for_fires(40);

    // Halfword targets with reads still owed
    phase = "branch_flush";
    wait_for_read_in_flight();
    apply_branch(32'h0000_01A2);
    wait_for_fires(6);
    wait_for_read_in_flight();
    apply_branch(32'h0000_00F6);
    wait_for_fires(6);
    wait_for_read_in_flight();
    apply_branch(32'h0000_0256);
    wait_for_fires(10);

    // Walks across the marked words 70 and 71
    phase = "error_flag";
    apply_branch(32'h0000_0112);
    wait_for_fires(16);

    phase = "backpressure";
    random_ready = 1'b1;
    apply_branch(32'h0000_0300);
    wait_for_fires(120);
    random_ready = 1'b0;
    wait_for_fires(4);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== bench/tb_axi_mem.sv ====
`timescale 1ns/1ps
/* Read-only AXI4-Lite slave, 256 words, address bits above 9 are ignored
   Contents and error marks are loaded by the bench before reset ends
   Responses come back in order, 1 to 4 cycles after the accept */
module tb_axi_mem (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [31:0]                  rnd_i,
  input  logic [fetch_pkg::ADDR_W-1:0] araddr_i,
  input  logic                         arvalid_i,
  output logic                         arready_o,
  output logic                         rvalid_o,
  output logic [fetch_pkg::DATA_W-1:0] rdata_o,
  output fetch_pkg::axi_resp_e         rresp_o
);
  import fetch_pkg::*;

  localparam int MEM_WORDS = 256;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  // Words that answer with SLVERR
  logic              bad [MEM_WORDS];

  // Accepted reads, oldest first, with the cycle they may answer in
  logic [7:0]        pend_idx [$];
  int                pend_due [$];
  int                cycle;
  logic [31:0]       r;

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = OKAY;
    cycle     = 0;
    forever begin
      @(posedge clk_i);
      // Random word is frozen at the edge for the whole cycle
      r = rnd_i;
      cycle++;
      if (!rst_ni) begin
        pend_idx.delete();
        pend_due.delete();
      end else begin
        // Beat on the bus was taken at this edge
        if (rvalid_o) begin
          void'(pend_idx.pop_front());
          void'(pend_due.pop_front());
        end
        if (arvalid_i && arready_o) begin
          pend_idx.push_back(araddr_i[9:2]);
          pend_due.push_back(cycle + int'(r[17:16]));
        end
      end
      #1;
      // Ready about three cycles in four
      arready_o = (r[20:19] != 2'b00);
      if (pend_idx.size() > 0 && pend_due[0] <= cycle) begin
        rvalid_o = 1'b1;
        rdata_o  = mem[pend_idx[0]];
        rresp_o  = bad[pend_idx[0]] ? SLVERR : OKAY;
      end else begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        rresp_o  = OKAY;
      end
    end
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
/* Free-running 10 ns clock from time zero
   Active-low reset held for 3 rising edges, released 1 ns after the third */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release lines up with the 1 ns stimulus offset
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
/* Instruction prefetch over the AXI4-Lite read channels, NUM_REQS from 1 to 4
   R channel has no rready; the memory side must never stall responses
   Fetching begins at the first branch after reset */
module fetch_unit #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Consumer side
  input  logic                         req_i,
  input  logic                         branch_i,
  input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] out_addr_o,
  output logic [fetch_pkg::DATA_W-1:0] out_rdata_o,
  output logic                         out_err_o,
  // AR channel
  output logic [fetch_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                         m_arvalid_o,
  input  logic                         m_arready_i,
  // R channel
  input  logic                         m_rvalid_i,
  input  logic [fetch_pkg::DATA_W-1:0] m_rdata_i,
  input  fetch_pkg::axi_resp_e         m_rresp_i
);

  // Push from controller into the FIFO
  logic push_valid;
  logic push_err;
  logic fifo_ready;

  fetch_req_ctrl #(
    .NUM_REQS (NUM_REQS)
  ) u_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fifo_ready_i  (fifo_ready),
    .araddr_o      (m_araddr_o),
    .arvalid_o     (m_arvalid_o),
    .arready_i     (m_arready_i),
    .rvalid_i      (m_rvalid_i),
    .rresp_i       (m_rresp_i),
    .push_valid_o  (push_valid),
    .push_err_o    (push_err)
  );

  // Read data goes straight in; the controller only qualifies it
  fetch_fifo #(
    .NUM_REQS (NUM_REQS)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch_i),
    .in_valid_i  (push_valid),
    .in_ready_o  (fifo_ready),
    .in_addr_i   (branch_addr_i),
    .in_rdata_i  (m_rdata_i),
    .in_err_i    (push_err),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_addr_o  (out_addr_o),
    .out_rdata_o (out_rdata_o),
    .out_err_o   (out_err_o)
  );

endmodule

// ==== logic/fetch_req_ctrl.sv ====
`timescale 1ns/1ps
/* AR channel master for instruction fetch with up to NUM_REQS reads in flight
   Idle after reset until the first branch; responses must come back in order
   Responses owed at a branch are dropped, never pushed */
module fetch_req_ctrl #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         branch_i,
  input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
  input  logic                         fifo_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] araddr_o,
  output logic                         arvalid_o,
  input  logic                         arready_i,
  input  logic                         rvalid_i,
  input  fetch_pkg::axi_resp_e         rresp_i,
  output logic                         push_valid_o,
  output logic                         push_err_o
);
  import fetch_pkg::*;

  localparam int unsigned CNT_W = $clog2(NUM_REQS + 1);
  localparam logic [CNT_W-1:0] MAX_OUT = CNT_W'(NUM_REQS);

  req_state_e        state_q, state_d;
  logic              started_q;
  logic [CNT_W-1:0]  outst_q, outst_d;
  logic [CNT_W-1:0]  disc_q, disc_d;
  logic [ADDR_W-1:0] next_addr_q;
  logic [ADDR_W-1:0] araddr_q;
  logic [ADDR_W-1:0] branch_word;
  logic [ADDR_W-1:0] issue_addr;
  logic              ar_free;
  logic              may_issue;
  logic              issue;
  logic              drop;

  //////////////////////////////
  // Request issue
  //////////////////////////////

  assign branch_word = {branch_addr_i[ADDR_W-1:2], 2'b00};

  // Channel is free when idle or when the held AR is taken this cycle
  assign ar_free = (state_q == REQ_IDLE) | arready_i;

  // A branch frees the FIFO, so it need not wait for fifo_ready
  assign may_issue = req_i & (branch_i | (started_q & fifo_ready_i));

  // Count includes a presented AR, which bounds accepted reads too
  assign issue      = may_issue & ar_free & (outst_q < MAX_OUT);
  assign issue_addr = branch_i ? branch_word : next_addr_q;

  always_comb begin
    state_d = state_q;
    if (issue) begin
      state_d = REQ_ADDR;
    end else if (ar_free) begin
      state_d = REQ_IDLE;
    end
  end

  assign arvalid_o = (state_q == REQ_ADDR);
  assign araddr_o  = araddr_q;

  //////////////////////////////
  // Responses
  //////////////////////////////

  // Responses still owed from before a branch are dropped
  assign drop         = rvalid_i & (disc_q != '0);
  assign push_valid_o = rvalid_i & (disc_q == '0);
  assign push_err_o   = (rresp_i != OKAY);

  assign outst_d = outst_q + CNT_W'(issue) - CNT_W'(rvalid_i);

  always_comb begin
    disc_d = disc_q;
    if (branch_i) begin
      // Every read owed after this cycle belongs to the old stream
      disc_d = outst_q - CNT_W'(rvalid_i);
    end else if (drop) begin
      disc_d = disc_q - CNT_W'(1);
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= REQ_IDLE;
      started_q <= 1'b0;
      outst_q   <= '0;
      disc_q    <= '0;
    end else begin
      state_q <= state_d;
      outst_q <= outst_d;
      disc_q  <= disc_d;
      if (branch_i) begin
        started_q <= 1'b1;
      end
    end
  end

  // Address steps one word per issued request, reloaded on a branch
  always_ff @(posedge clk_i) begin
    if (issue) begin
      araddr_q    <= issue_addr;
      next_addr_q <= issue_addr + ADDR_W'(4);
    end else if (branch_i) begin
      next_addr_q <= branch_word;
    end
  end

endmodule

// ==== logic/fetch_fifo.sv ====
`timescale 1ns/1ps
/* Fetch word FIFO of NUM_REQS+1 entries with a bypass from the push port
   Instructions may start at a halfword offset and span two words
   The producer must keep pushes within the room that in_ready_o reserves
   clear_i empties the FIFO at the next edge and wins over a push */
module fetch_fifo #(
  parameter int unsigned NUM_REQS = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic [fetch_pkg::ADDR_W-1:0] in_addr_i,
  input  logic [fetch_pkg::DATA_W-1:0] in_rdata_i,
  input  logic                         in_err_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] out_addr_o,
  output logic [fetch_pkg::DATA_W-1:0] out_rdata_o,
  output logic                         out_err_o
);
  import fetch_pkg::*;

  // One spare entry beyond the reads that may be in flight
  localparam int unsigned DEPTH = NUM_REQS + 1;

  // Entry 0 is the head word
  logic [DEPTH-1:0][DATA_W-1:0] data_q, data_d;
  logic [DEPTH-1:0]             err_q, err_d;
  logic [DEPTH-1:0]             valid_q, valid_d;
  logic [DEPTH-1:0]             lowest_free;
  logic [DEPTH-1:0]             valid_pushed;
  logic [DEPTH-1:0]             entry_we;

  logic [DATA_W-1:0] head_data;
  logic [DATA_W-1:0] next_data;
  logic              head_err;
  logic              next_err;
  logic              head_vld;
  logic              next_vld;
  logic [15:0]       cur_half;
  logic              unaligned;
  logic              is32;
  logic              fire;
  logic              pop;

  // Halfword address of the instruction at the output
  logic [ADDR_W-1:1] addr_q;

  //////////////////////////////
  // Head and second word
  //////////////////////////////

  // Empty head falls through to the incoming response
  assign head_data = valid_q[0] ? data_q[0] : in_rdata_i;
  assign head_err  = valid_q[0] ? err_q[0] : in_err_i;
  assign head_vld  = valid_q[0] | in_valid_i;

  // Second word comes from entry 1, or from the push behind a stored head
  assign next_data = valid_q[1] ? data_q[1] : in_rdata_i;
  assign next_err  = valid_q[1] ? err_q[1] : in_err_i;
  assign next_vld  = valid_q[1] | (valid_q[0] & in_valid_i);

  // Low halfword of the current instruction decides its size
  assign unaligned = addr_q[1];
  assign cur_half  = unaligned ? head_data[DATA_W-1:16] : head_data[15:0];
  assign is32      = (cur_half[1:0] == 2'b11);

  //////////////////////////////
  // Realignment
  //////////////////////////////

  always_comb begin
    if (unaligned) begin
      // Upper half of head, then lower half of the next word
      out_rdata_o = {next_data[15:0], head_data[DATA_W-1:16]};
      // Second word only matters for a 32-bit instruction
      out_err_o   = head_err | (is32 & next_err);
      out_valid_o = (is32 ? next_vld : head_vld) & ~clear_i;
    end else begin
      out_rdata_o = head_data;
      out_err_o   = head_err;
      out_valid_o = head_vld & ~clear_i;
    end
  end

  assign fire = out_valid_o & out_ready_i;

  // Head word is done once an instruction ends at or beyond its top
  assign pop = fire & (unaligned | is32);

  // Room for every read that may still be in flight
  assign in_ready_o = ~valid_q[DEPTH-NUM_REQS];

  //////////////////////////////
  // Shift entries
  //////////////////////////////

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    logic              above_vld;
    logic              above_pushed;
    logic [DATA_W-1:0] above_data;
    logic              above_err;

    // Top entry has nothing above it, so it only ever takes the push
    if (i == DEPTH - 1) begin : g_top
      assign above_vld    = 1'b0;
      assign above_pushed = 1'b0;
      assign above_data   = in_rdata_i;
      assign above_err    = in_err_i;
    end else begin : g_mid
      assign above_vld    = valid_q[i+1];
      assign above_pushed = valid_pushed[i+1];
      assign above_data   = data_q[i+1];
      assign above_err    = err_q[i+1];
    end

    // Write pointer is the first empty entry
    if (i == 0) begin : g_first
      assign lowest_free[i] = ~valid_q[i];
    end else begin : g_rest
      assign lowest_free[i] = ~valid_q[i] & valid_q[i-1];
    end

    assign valid_pushed[i] = valid_q[i] | (in_valid_i & lowest_free[i]);

    // A pop moves everything down one entry, the push included
    assign valid_d[i]  = ~clear_i & (pop ? above_pushed : valid_pushed[i]);
    assign entry_we[i] = pop ? above_pushed : (in_valid_i & lowest_free[i]);

    // Empty neighbour above means the push lands here
    assign data_d[i] = above_vld ? above_data : in_rdata_i;
    assign err_d[i]  = above_vld ? above_err : in_err_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (entry_we[i]) begin
        data_q[i] <= data_d[i];
        err_q[i]  <= err_d[i];
      end
    end
  end

  //////////////////////////////
  // Instruction address
  //////////////////////////////

  // Branch target on clear, otherwise step by one or two halfwords
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      addr_q <= in_addr_i[ADDR_W-1:1];
    end else if (fire) begin
      addr_q <= addr_q + {{(ADDR_W-3){1'b0}}, is32, ~is32};
    end
  end

  assign out_addr_o = {addr_q, 1'b0};

endmodule

// ==== logic/fetch_pkg.sv ====
/* Widths and encodings shared by the prefetch subsystem
   Addresses and fetch words are one 32-bit word; fetch is read-only */
package fetch_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Byte address width of the AXI read port
  localparam int unsigned ADDR_W = 32;
  // One fetch word per read beat
  localparam int unsigned DATA_W = 32;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // AXI read response code, as carried on rresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Request controller state
  // REQ_ADDR holds the AR channel until the slave accepts it
  typedef enum logic {
    REQ_IDLE = 1'b0,
    REQ_ADDR = 1'b1
  } req_state_e;

endpackage
